//--- src/mips8_config.svh
`ifndef MIPS8_CONFIG_SVH
`define MIPS8_CONFIG_SVH

// datapath and register widths
`define MIPS8_DW 8
`define MIPS8_IW 32
`define MIPS8_RW 5

// word addressed memories
`define MIPS8_IAW 8
`define MIPS8_DAW 4

`define MIPS8_RESET_PC 0

`endif

//--- src/mips8_pkg.sv
`include "mips8_config.svh"

package mips8_pkg;

    typedef logic [`MIPS8_DW-1:0]  word_t;
    typedef logic [`MIPS8_IAW-1:0] pc_t;
    typedef logic [`MIPS8_DAW-1:0] daddr_t;
    typedef logic [`MIPS8_RW-1:0]  reg_idx_t;
    typedef logic [`MIPS8_IW-1:0]  instr_t;

    typedef enum logic [1:0] {
        fmt_r   = 2'd0,
        fmt_j   = 2'd1,
        fmt_i   = 2'd2,
        fmt_bad = 2'd3
    } format_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_read,
        st_exec,
        st_wb
    } state_e;

    // primary opcodes
    localparam logic [5:0] op_rtype = 6'b000000;
    localparam logic [5:0] op_jal   = 6'b000011;
    localparam logic [5:0] op_beq   = 6'b000100;
    localparam logic [5:0] op_bne   = 6'b000101;
    localparam logic [5:0] op_addiu = 6'b001001;
    localparam logic [5:0] op_lw    = 6'b100011;

    // funct codes, register format
    localparam logic [5:0] fn_jr   = 6'b001000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_slt  = 6'b101010;

    typedef struct packed {
        format_e    format;
        logic [5:0] opcode;   // funct when fmt_r
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   dest;
        word_t      imm;
        pc_t        jtarget;
    } dec_s;

    typedef struct packed {
        logic   legal;
        logic   write;
        logic   load;
        word_t  data;
        daddr_t daddr;
    } alu_res_s;

    typedef struct packed {
        pc_t      pc;
        pc_t      next_pc;
        logic     legal;
        logic     write;
        reg_idx_t dst;
        word_t    data;
    } commit_s;

endpackage

//--- src/cpu_control.sv
`timescale 1ns/1ps
`include "mips8_config.svh"

module cpu_control (
    input  logic              clk,
    input  logic              rst,
    input  mips8_pkg::pc_t    next_pc,
    input  mips8_pkg::instr_t instr,
    input  mips8_pkg::dec_s   dec,
    input  mips8_pkg::word_t  rd1,
    input  mips8_pkg::word_t  rd2,
    output mips8_pkg::state_e state,
    output mips8_pkg::pc_t    instr_addr,
    output mips8_pkg::pc_t    pc,
    output mips8_pkg::instr_t ir,
    output mips8_pkg::dec_s   dec_q,
    output mips8_pkg::word_t  op1,
    output mips8_pkg::word_t  op2
);

    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mips8_pkg::st_fetch;
            pc    <= mips8_pkg::pc_t'(`MIPS8_RESET_PC);
        end else begin
            case (state)
                mips8_pkg::st_fetch:  state <= mips8_pkg::st_decode;
                mips8_pkg::st_decode: state <= mips8_pkg::st_read;
                mips8_pkg::st_read:   state <= mips8_pkg::st_exec;
                mips8_pkg::st_exec:   state <= mips8_pkg::st_wb;
                default: begin
                    state <= mips8_pkg::st_fetch;
                    pc    <= next_pc;   // retire, move to next instruction
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mips8_pkg::st_fetch) ir <= instr;
        if (state == mips8_pkg::st_decode) dec_q <= dec;
        if (state == mips8_pkg::st_read) begin
            op1 <= rd1;
            op2 <= rd2;
        end
    end

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/1ps
`include "mips8_config.svh"

module instr_decoder (
    input  mips8_pkg::instr_t ir,
    output mips8_pkg::dec_s   dec
);

    logic [5:0] opcode;

    assign opcode = ir[31:26];

    always_comb begin
        dec.rs      = ir[25:21];
        dec.rt      = ir[20:16];
        dec.imm     = ir[`MIPS8_DW-1:0];    // low byte of imm16
        dec.jtarget = ir[`MIPS8_IAW-1:0];   // low byte of target26
        dec.opcode  = opcode;
        dec.dest    = '0;
        case (opcode)
            mips8_pkg::op_rtype: begin
                dec.format = mips8_pkg::fmt_r;
                dec.opcode = ir[5:0];
                dec.dest   = ir[15:11];
            end
            mips8_pkg::op_jal: begin
                dec.format = mips8_pkg::fmt_j;
                dec.dest   = '1;    // link register r31
            end
            mips8_pkg::op_addiu, mips8_pkg::op_lw,
            mips8_pkg::op_beq, mips8_pkg::op_bne: begin
                dec.format = mips8_pkg::fmt_i;
                dec.dest   = ir[20:16];
            end
            default: dec.format = mips8_pkg::fmt_bad;
        endcase
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  logic                 rst,
    input  mips8_pkg::reg_idx_t  rs,
    input  mips8_pkg::reg_idx_t  rt,
    output mips8_pkg::word_t     rd1,
    output mips8_pkg::word_t     rd2,
    input  logic                 we,
    input  mips8_pkg::reg_idx_t  wa,
    input  mips8_pkg::word_t     wd
);

    localparam int nregs = 2 ** $bits(mips8_pkg::reg_idx_t);

    mips8_pkg::word_t regs [nregs];

    // r0 is never written, so it stays at its reset zero
    assign rd1 = regs[rs];
    assign rd2 = regs[rt];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

endmodule

//--- src/alu_unit.sv
`timescale 1ns/1ps
`include "mips8_config.svh"

module alu_unit (
    input  logic                clk,
    input  mips8_pkg::state_e   state,
    input  mips8_pkg::pc_t      pc,
    input  mips8_pkg::dec_s     dec,
    input  mips8_pkg::word_t    op1,
    input  mips8_pkg::word_t    op2,
    output mips8_pkg::alu_res_s res,
    output mips8_pkg::daddr_t   data_addr,
    output logic                data_rd_en
);

    mips8_pkg::alu_res_s res_d;
    mips8_pkg::word_t    sum_imm;

    assign sum_imm   = op1 + dec.imm;
    assign data_addr = res.daddr;

    always_comb begin
        res_d       = '0;
        res_d.daddr = sum_imm[`MIPS8_DAW-1:0];
        case (dec.format)
            mips8_pkg::fmt_r: begin
                case (dec.opcode)
                    mips8_pkg::fn_slt: begin
                        res_d.legal = 1'b1;
                        res_d.write = 1'b1;
                        res_d.data  = ($signed(op1) < $signed(op2)) ?
                                      mips8_pkg::word_t'(1) : '0;
                    end
                    mips8_pkg::fn_addu: begin
                        res_d.legal = 1'b1;
                        res_d.write = 1'b1;
                        res_d.data  = op1 + op2;   // wraps
                    end
                    mips8_pkg::fn_jr: res_d.legal = 1'b1;
                    default: ;
                endcase
            end
            mips8_pkg::fmt_i: begin
                case (dec.opcode)
                    mips8_pkg::op_addiu: begin
                        res_d.legal = 1'b1;
                        res_d.write = 1'b1;
                        res_d.data  = sum_imm;
                    end
                    mips8_pkg::op_lw: begin
                        res_d.legal = 1'b1;
                        res_d.write = 1'b1;
                        res_d.load  = 1'b1;
                    end
                    mips8_pkg::op_beq, mips8_pkg::op_bne: res_d.legal = 1'b1;
                    default: ;
                endcase
            end
            mips8_pkg::fmt_j: begin
                res_d.legal = 1'b1;
                res_d.write = 1'b1;
                res_d.data  = mips8_pkg::word_t'(pc + 1'b1);   // link value
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == mips8_pkg::st_exec) begin
            res        <= res_d;
            data_rd_en <= res_d.load;
        end else begin
            data_rd_en <= 1'b0;   // high for the wb cycle only
        end
    end

endmodule

//--- src/next_pc_unit.sv
`timescale 1ns/1ps

module next_pc_unit (
    input  logic              clk,
    input  mips8_pkg::state_e state,
    input  mips8_pkg::pc_t    pc,
    input  mips8_pkg::dec_s   dec,
    input  mips8_pkg::word_t  op1,
    input  mips8_pkg::word_t  op2,
    output mips8_pkg::pc_t    next_pc
);

    mips8_pkg::pc_t seq_pc;
    mips8_pkg::pc_t br_pc;
    mips8_pkg::pc_t target;

    assign seq_pc = pc + 1'b1;
    assign br_pc  = pc + mips8_pkg::pc_t'(dec.imm);   // word offset from pc

    always_comb begin
        target = seq_pc;
        case (dec.format)
            mips8_pkg::fmt_r: begin
                if (dec.opcode == mips8_pkg::fn_jr) target = mips8_pkg::pc_t'(op1);
            end
            mips8_pkg::fmt_i: begin
                if (dec.opcode == mips8_pkg::op_beq && op1 == op2) target = br_pc;
                if (dec.opcode == mips8_pkg::op_bne && op1 != op2) target = br_pc;
            end
            mips8_pkg::fmt_j: target = dec.jtarget;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == mips8_pkg::st_exec) next_pc <= target;
    end

endmodule

//--- src/write_back.sv
`timescale 1ns/1ps

module write_back (
    input  logic                 clk,
    input  logic                 rst,
    input  mips8_pkg::state_e    state,
    input  mips8_pkg::pc_t       pc,
    input  mips8_pkg::dec_s      dec,
    input  mips8_pkg::alu_res_s  res,
    input  mips8_pkg::pc_t       next_pc,
    input  mips8_pkg::word_t     data_in,
    output logic                 we,
    output mips8_pkg::reg_idx_t  wa,
    output mips8_pkg::word_t     wd,
    output logic                 commit_valid,
    output mips8_pkg::commit_s   commit
);

    logic in_wb;

    assign in_wb = (state == mips8_pkg::st_wb);

    assign we = in_wb && res.write;
    assign wa = dec.dest;
    assign wd = res.load ? data_in : res.data;   // load data arrives in wb

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= in_wb;
        end
    end

    always_ff @(posedge clk) begin
        if (in_wb) begin
            commit.pc      <= pc;
            commit.next_pc <= next_pc;
            commit.legal   <= res.legal;
            commit.write   <= res.write;
            commit.dst     <= wa;
            commit.data    <= wd;
        end
    end

endmodule

//--- src/mips8_core.sv
`timescale 1ns/1ps

module mips8_core (
    input  logic                clk,
    input  logic                rst,
    output mips8_pkg::pc_t      instr_addr,
    input  mips8_pkg::instr_t   instr,
    output mips8_pkg::daddr_t   data_addr,
    output logic                data_rd_en,
    input  mips8_pkg::word_t    data_in,
    output logic                commit_valid,
    output mips8_pkg::commit_s  commit
);

    mips8_pkg::state_e   state;
    mips8_pkg::pc_t      pc;
    mips8_pkg::pc_t      next_pc;
    mips8_pkg::instr_t   ir;
    mips8_pkg::dec_s     dec;
    mips8_pkg::dec_s     dec_q;
    mips8_pkg::word_t    rd1;
    mips8_pkg::word_t    rd2;
    mips8_pkg::word_t    op1;
    mips8_pkg::word_t    op2;
    mips8_pkg::alu_res_s res;
    logic                we;
    mips8_pkg::reg_idx_t wa;
    mips8_pkg::word_t    wd;

    cpu_control cpu_control_i (
        .clk(clk), .rst(rst), .next_pc(next_pc), .instr(instr), .dec(dec),
        .rd1(rd1), .rd2(rd2), .state(state), .instr_addr(instr_addr), .pc(pc),
        .ir(ir), .dec_q(dec_q), .op1(op1), .op2(op2)
    );

    instr_decoder instr_decoder_i (.ir(ir), .dec(dec));

    reg_file reg_file_i (
        .clk(clk), .rst(rst), .rs(dec_q.rs), .rt(dec_q.rt), .rd1(rd1), .rd2(rd2),
        .we(we), .wa(wa), .wd(wd)
    );

    alu_unit alu_unit_i (
        .clk(clk), .state(state), .pc(pc), .dec(dec_q), .op1(op1), .op2(op2),
        .res(res), .data_addr(data_addr), .data_rd_en(data_rd_en)
    );

    next_pc_unit next_pc_unit_i (
        .clk(clk), .state(state), .pc(pc), .dec(dec_q), .op1(op1), .op2(op2),
        .next_pc(next_pc)
    );

    write_back write_back_i (
        .clk(clk), .rst(rst), .state(state), .pc(pc), .dec(dec_q), .res(res),
        .next_pc(next_pc), .data_in(data_in), .we(we), .wa(wa), .wd(wd),
        .commit_valid(commit_valid), .commit(commit)
    );

endmodule

//--- test/tb_mips8_core.sv
`timescale 1ns/1ps
`include "mips8_config.svh"

module tb_mips8_core;

    logic               clk = 1'b0;
    logic               rst;
    mips8_pkg::pc_t     instr_addr;
    mips8_pkg::instr_t  instr;
    mips8_pkg::daddr_t  data_addr;
    logic               data_rd_en;
    mips8_pkg::word_t   data_in;
    logic               commit_valid;
    mips8_pkg::commit_s commit;

    mips8_pkg::instr_t  imem [256];
    mips8_pkg::word_t   dmem [16];
    mips8_pkg::word_t   reg_shadow [32];
    mips8_pkg::commit_s expected [$];
    int                 cycle;
    int                 limit;

    mips8_core mips8_core_i (.*);

    always #20 clk = ~clk;

    // memories answer within the cycle
    always @(negedge clk) begin
        instr   <= imem[instr_addr];
        data_in <= data_rd_en ? dmem[data_addr] : 'x;   // bus idle without a read
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL time %0t %s got %0h expected %0h", $time, name, got, want);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic is_load(input mips8_pkg::instr_t word);
        return word[31:26] == 6'b100011;   // lw opcode
    endfunction

    // base register plus the low bits of the offset
    function automatic mips8_pkg::daddr_t load_address(input mips8_pkg::instr_t word);
        return mips8_pkg::daddr_t'(reg_shadow[word[25:21]] + word[7:0]);
    endfunction

    task automatic load_vectors();
        int              fd;
        int              n;
        logic [7:0]      tag;
        logic [31:0]     a, v;
        logic [31:0]     p, np, lg, wr, rg, dt;
        logic [8*96-1:0] rest;
        fd = $fopen("test/mips8_vectors.txt", "r");
        if (fd == 0) abort_run("cannot open test/mips8_vectors.txt");
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "#": n = $fgets(rest, fd);   // comment line
                "i": begin
                    n = $fscanf(fd, "%h %h", a, v);
                    if (n != 2) abort_run("malformed instruction record in the vector file");
                    imem[a[7:0]] = v;
                end
                "d": begin
                    n = $fscanf(fd, "%h %h", a, v);
                    if (n != 2) abort_run("malformed data record in the vector file");
                    dmem[a[3:0]] = v[7:0];
                end
                "c": begin
                    n = $fscanf(fd, "%h %h %h %h %h %h", p, np, lg, wr, rg, dt);
                    if (n != 6) abort_run("malformed commit record in the vector file");
                    // same field order as commit_s
                    expected.push_back({p[7:0], np[7:0], lg[0], wr[0], rg[4:0], dt[7:0]});
                end
                default: abort_run("unknown record tag in the vector file");
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        mips8_pkg::commit_s want;
        mips8_pkg::instr_t  cur;
        rst     = 1'b1;
        instr   = '0;
        data_in = '0;
        cycle   = 0;
        // unprogrammed words decode as an illegal opcode
        for (int a = 0; a < 256; a++) imem[a] = {6'h3f, 18'h0, 8'(a)};
        for (int a = 0; a < 16; a++) dmem[a] = {4'(~a), 4'(a)};
        for (int r = 0; r < 32; r++) reg_shadow[r] = '0;
        load_vectors();
        if (expected.size() == 0) abort_run("no commit records in the vector file");
        limit = 30 * expected.size();   // six instruction times per commit
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare_value("commit_valid", 32'(commit_valid), 0);
        compare_value("data_rd_en", 32'(data_rd_en), 0);
        compare_value("instr_addr", 32'(instr_addr), `MIPS8_RESET_PC);
        while (expected.size() > 0) begin
            @(negedge clk);
            cycle++;
            if (cycle > limit) abort_run("timeout while waiting for commit pulses");
            compare_value("commit_valid", 32'(commit_valid), 32'(cycle % 5 == 0));
            cur = imem[expected[0].pc];
            if (cycle % 5 == 4 && is_load(cur)) begin
                compare_value("data_rd_en", 32'(data_rd_en), 1);
                compare_value("data_addr", 32'(data_addr), 32'(load_address(cur)));
            end else begin
                compare_value("data_rd_en", 32'(data_rd_en), 0);
            end
            if (commit_valid) begin
                want = expected.pop_front();
                compare_value("commit.pc", 32'(commit.pc), 32'(want.pc));
                compare_value("commit.next_pc", 32'(commit.next_pc), 32'(want.next_pc));
                compare_value("commit.legal", 32'(commit.legal), 32'(want.legal));
                compare_value("commit.write", 32'(commit.write), 32'(want.write));
                compare_value("commit.dst", 32'(commit.dst), 32'(want.dst));
                compare_value("commit.data", 32'(commit.data), 32'(want.data));
                if (want.write && want.dst != '0) begin
                    reg_shadow[want.dst] = want.data;   // r0 stays zero
                end
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

//--- mips8_core.f
+incdir+src
src/mips8_pkg.sv
src/cpu_control.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu_unit.sv
src/next_pc_unit.sv
src/write_back.sv
src/mips8_core.sv
test/tb_mips8_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mips8_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mips8_core \
    -f mips8_core.f -o sim_mips8_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mips8_core > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

//--- test/mips8_vectors.txt
# i word_addr instruction   d byte_addr byte   all values hex
# c pc next_pc legal write reg data   one per commit in retire order
i 00 24010005
i 01 2402fffd
i 02 00222021
i 03 0044282a
i 04 0082302a
i 05 8c270003
i 06 10210002
i 08 14210005
i 09 10220005
i 0a 14220002
i 0c 0c000020
i 20 03e00008
i 0d 24000033
i 0e 00004021
i 0f 0022683f
i 10 fc000000
d 08 5a
c 00 01 1 1 01 05
c 01 02 1 1 02 fd
c 02 03 1 1 04 02
c 03 04 1 1 05 01
c 04 05 1 1 06 00
c 05 06 1 1 07 5a
c 06 08 1 0 01 00
c 08 09 1 0 01 00
c 09 0a 1 0 02 00
c 0a 0c 1 0 02 00
c 0c 20 1 1 1f 0d
c 20 0d 1 0 00 00
c 0d 0e 1 1 00 33
c 0e 0f 1 1 08 00
c 0f 10 0 0 0d 00
c 10 11 0 0 00 00
